// File: design/coef_regs.sv
`timescale 1ns/1ps

module coef_regs (
	input  logic                clk,
	input  logic                aclr,
	input  logic                cfg_wr,
	input  filt_pkg::coef_cfg_t cfg_in,
	output filt_pkg::coef_cfg_t cfg
);

	// Identity kernel out of reset, so pixels pass through unchanged
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			cfg <= filt_pkg::CFG_IDENT;
		end else if (cfg_wr) begin
			cfg <= cfg_in;
		end
	end

endmodule

// File: design/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
	input  logic                       clk,
	input  logic                       aclr,
	input  filt_pkg::window_t          win,
	input  logic                       win_valid,
	input  filt_pkg::coef_cfg_t        cfg,
	output logic [filt_pkg::PIX_W-1:0] pix_out,
	output logic                       out_valid
);

	logic [filt_pkg::PIX_W-1:0] pix [9];
	logic signed [filt_pkg::COEF_W-1:0] k [9];
	logic signed [filt_pkg::PIX_W+filt_pkg::COEF_W:0] prod [9];
	logic signed [filt_pkg::sum_w-1:0] acc;
	logic signed [filt_pkg::sum_w-1:0] shifted;
	logic prod_valid;

	assign pix[0] = win.p0;
	assign pix[1] = win.p1;
	assign pix[2] = win.p2;
	assign pix[3] = win.p3;
	assign pix[4] = win.p4;
	assign pix[5] = win.p5;
	assign pix[6] = win.p6;
	assign pix[7] = win.p7;
	assign pix[8] = win.p8;

	assign k[0] = cfg.k0;
	assign k[1] = cfg.k1;
	assign k[2] = cfg.k2;
	assign k[3] = cfg.k3;
	assign k[4] = cfg.k4;
	assign k[5] = cfg.k5;
	assign k[6] = cfg.k6;
	assign k[7] = cfg.k7;
	assign k[8] = cfg.k8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1, products
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixels are unsigned, so a zero sign bit goes on top before the multiply
	always_ff @(posedge clk) begin
		for (int i = 0; i < 9; i++) begin
			prod[i] <= $signed({1'b0, pix[i]}) * k[i];
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2, sum, shift and clamp
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		acc = '0;
		for (int i = 0; i < 9; i++) begin
			acc = acc + prod[i];
		end
		shifted = acc >>> cfg.shift;
	end

	always_ff @(posedge clk) begin
		if (shifted[filt_pkg::sum_w-1]) begin
			pix_out <= '0;
		end else if (|shifted[filt_pkg::sum_w-2:filt_pkg::PIX_W]) begin
			pix_out <= '1;
		end else begin
			pix_out <= shifted[filt_pkg::PIX_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= prod_valid;
		end
	end

endmodule

// File: design/filt_pkg.sv
package filt_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int PIX_W = 8;
	localparam int COEF_W = 4;
	localparam int sum_w = 16;

	localparam int COL_W = $clog2(IMG_W);
	localparam int FRM_W = $clog2(IMG_W * IMG_H);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(IMG_W - 1);
	localparam logic [FRM_W-1:0] FRM_LAST = FRM_W'(IMG_W * IMG_H - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Row machine encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {ST_IDLE, ST_ZF, ST_A, ST_B, ST_C} row_state_t;

	// SEL_NONE feeds a row of zeros into the window
	typedef enum logic [1:0] {
		SEL_NONE = 2'd0,
		SEL_C = 2'd1,
		SEL_B = 2'd2,
		SEL_A = 2'd3
	} row_sel_t;

	typedef struct packed {
		row_sel_t top;
		row_sel_t mid;
		row_sel_t bot;
	} row_sels_t;

	typedef struct packed {
		logic a;
		logic b;
		logic c;
	} ram_ctl_t;

	// Coefficients in raster order, k0 is the top-left tap
	typedef struct packed {
		logic signed [COEF_W-1:0] k0;
		logic signed [COEF_W-1:0] k1;
		logic signed [COEF_W-1:0] k2;
		logic signed [COEF_W-1:0] k3;
		logic signed [COEF_W-1:0] k4;
		logic signed [COEF_W-1:0] k5;
		logic signed [COEF_W-1:0] k6;
		logic signed [COEF_W-1:0] k7;
		logic signed [COEF_W-1:0] k8;
		logic [2:0] shift;
	} coef_cfg_t;

	localparam coef_cfg_t CFG_IDENT = '{k4: COEF_W'(1), default: '0};

	typedef struct packed {
		logic [PIX_W-1:0] p0;
		logic [PIX_W-1:0] p1;
		logic [PIX_W-1:0] p2;
		logic [PIX_W-1:0] p3;
		logic [PIX_W-1:0] p4;
		logic [PIX_W-1:0] p5;
		logic [PIX_W-1:0] p6;
		logic [PIX_W-1:0] p7;
		logic [PIX_W-1:0] p8;
	} window_t;

endpackage

// File: design/filter_top.sv
`timescale 1ns/1ps

module filter_top (
	input  logic                       clk,
	input  logic                       aclr,
	input  logic [filt_pkg::PIX_W-1:0] pix_in,
	input  logic                       pix_valid,
	input  logic                       cfg_wr,
	input  filt_pkg::coef_cfg_t        cfg_in,
	output logic [filt_pkg::PIX_W-1:0] pix_out,
	output logic                       out_valid
);

	filt_pkg::ram_ctl_t wren;
	filt_pkg::ram_ctl_t rden;
	filt_pkg::row_sels_t sels;
	filt_pkg::window_t win;
	filt_pkg::coef_cfg_t cfg;
	logic [filt_pkg::COL_W-1:0] wr_addr;
	logic [filt_pkg::COL_W-1:0] rd_addr;
	logic [filt_pkg::PIX_W-1:0] ram_a;
	logic [filt_pkg::PIX_W-1:0] ram_b;
	logic [filt_pkg::PIX_W-1:0] ram_c;
	logic win_valid;
	logic data_end;

	line_wr_ctrl i_line_wr_ctrl (
		.clk       (clk),
		.aclr      (aclr),
		.pix_valid (pix_valid),
		.wren      (wren),
		.wr_addr   (wr_addr)
	);

	row_ram i_ram_a (
		.clk     (clk),
		.wren    (wren.a),
		.wr_addr (wr_addr),
		.wr_data (pix_in),
		.rden    (rden.a),
		.rd_addr (rd_addr),
		.rd_data (ram_a)
	);

	row_ram i_ram_b (
		.clk     (clk),
		.wren    (wren.b),
		.wr_addr (wr_addr),
		.wr_data (pix_in),
		.rden    (rden.b),
		.rd_addr (rd_addr),
		.rd_data (ram_b)
	);

	row_ram i_ram_c (
		.clk     (clk),
		.wren    (wren.c),
		.wr_addr (wr_addr),
		.wr_data (pix_in),
		.rden    (rden.c),
		.rd_addr (rd_addr),
		.rd_data (ram_c)
	);

	gen_ram_rden i_gen_ram_rden (
		.clk      (clk),
		.aclr     (aclr),
		.wren     (wren),
		.sels     (sels),
		.rden     (rden),
		.rd_addr  (rd_addr),
		.data_end (data_end)
	);

	window_former i_window_former (
		.clk       (clk),
		.aclr      (aclr),
		.sels      (sels),
		.ram_a     (ram_a),
		.ram_b     (ram_b),
		.ram_c     (ram_c),
		.win       (win),
		.win_valid (win_valid)
	);

	coef_regs i_coef_regs (
		.clk    (clk),
		.aclr   (aclr),
		.cfg_wr (cfg_wr),
		.cfg_in (cfg_in),
		.cfg    (cfg)
	);

	conv_mac i_conv_mac (
		.clk       (clk),
		.aclr      (aclr),
		.win       (win),
		.win_valid (win_valid),
		.cfg       (cfg),
		.pix_out   (pix_out),
		.out_valid (out_valid)
	);

	// Last read of a frame comes out of the MAC five cycles later
	a_last_out: assert property (
		@(posedge clk) disable iff (aclr)
		data_end |-> ##5 out_valid
	);

endmodule

// File: design/gen_ram_rden.sv
`timescale 1ns/1ps

module gen_ram_rden (
	input  logic                       clk,
	input  logic                       aclr,
	input  filt_pkg::ram_ctl_t         wren,
	output filt_pkg::row_sels_t        sels,
	output filt_pkg::ram_ctl_t         rden,
	output logic [filt_pkg::COL_W-1:0] rd_addr,
	output logic                       data_end
);

	filt_pkg::row_state_t top_st;
	filt_pkg::row_state_t mid_st;
	filt_pkg::row_state_t bot_st;
	filt_pkg::row_sels_t sel_c;
	logic [filt_pkg::FRM_W-1:0] wr_cnt;
	logic [filt_pkg::FRM_W-1:0] frm_cnt;
	logic [filt_pkg::COL_W-1:0] col_cnt;
	logic [filt_pkg::COL_W-1:0] zf_cnt;
	logic start;
	logic row_end;
	logic zero_end;
	logic count_row;
	logic count_zero;

	function automatic filt_pkg::row_sel_t state_sel(input filt_pkg::row_state_t st);
		case (st)
			filt_pkg::ST_A: return filt_pkg::SEL_A;
			filt_pkg::ST_B: return filt_pkg::SEL_B;
			filt_pkg::ST_C: return filt_pkg::SEL_C;
			default: return filt_pkg::SEL_NONE;
		endcase
	endfunction

	function automatic logic sel_pair_ok(input filt_pkg::row_sel_t x, input filt_pkg::row_sel_t y);
		return (x == filt_pkg::SEL_NONE) || (y == filt_pkg::SEL_NONE) || (x != y);
	endfunction

	// The middle machine is never in ST_ZF, so it paces every row
	assign count_row = (mid_st != filt_pkg::ST_IDLE);
	assign count_zero = (top_st == filt_pkg::ST_ZF) || (bot_st == filt_pkg::ST_ZF);

	always_comb begin
		sel_c.top = state_sel(top_st);
		sel_c.mid = state_sel(mid_st);
		sel_c.bot = state_sel(bot_st);
	end

	assign rden.a = (sel_c.top == filt_pkg::SEL_A) || (sel_c.mid == filt_pkg::SEL_A) ||
		(sel_c.bot == filt_pkg::SEL_A);
	assign rden.b = (sel_c.top == filt_pkg::SEL_B) || (sel_c.mid == filt_pkg::SEL_B) ||
		(sel_c.bot == filt_pkg::SEL_B);
	assign rden.c = (sel_c.top == filt_pkg::SEL_C) || (sel_c.mid == filt_pkg::SEL_C) ||
		(sel_c.bot == filt_pkg::SEL_C);
	assign rd_addr = col_cnt;

	// Once the first row is in RAM a the machines may start
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			wr_cnt <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (|wren) begin
				wr_cnt <= wr_cnt + 1'b1;
				start <= (wr_cnt[filt_pkg::FRM_W-1:filt_pkg::COL_W] == '0) &&
					(wr_cnt[filt_pkg::COL_W-1:0] == filt_pkg::COL_LAST);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Row machines
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			top_st <= filt_pkg::ST_IDLE;
		end else begin
			case (top_st)
				filt_pkg::ST_IDLE: if (start) top_st <= filt_pkg::ST_ZF;
				filt_pkg::ST_ZF: if (zero_end) top_st <= filt_pkg::ST_A;
				filt_pkg::ST_A: begin
					if (data_end) begin
						top_st <= filt_pkg::ST_IDLE;
					end else if (row_end) begin
						top_st <= filt_pkg::ST_B;
					end
				end
				filt_pkg::ST_B: if (row_end) top_st <= filt_pkg::ST_C;
				filt_pkg::ST_C: if (row_end) top_st <= filt_pkg::ST_A;
				default: top_st <= filt_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			mid_st <= filt_pkg::ST_IDLE;
		end else begin
			case (mid_st)
				filt_pkg::ST_IDLE: if (start) mid_st <= filt_pkg::ST_A;
				filt_pkg::ST_A: if (row_end) mid_st <= filt_pkg::ST_B;
				filt_pkg::ST_B: begin
					if (data_end) begin
						mid_st <= filt_pkg::ST_IDLE;
					end else if (row_end) begin
						mid_st <= filt_pkg::ST_C;
					end
				end
				filt_pkg::ST_C: if (row_end) mid_st <= filt_pkg::ST_A;
				default: mid_st <= filt_pkg::ST_IDLE;
			endcase
		end
	end

	// Bottom row turns to zeros after image row 7 has been read as a bottom row
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			bot_st <= filt_pkg::ST_IDLE;
		end else begin
			case (bot_st)
				filt_pkg::ST_IDLE: if (start) bot_st <= filt_pkg::ST_B;
				filt_pkg::ST_B: begin
					if (row_end && (frm_cnt[filt_pkg::FRM_W-1:filt_pkg::COL_W] ==
						filt_pkg::FRM_LAST[filt_pkg::FRM_W-1:filt_pkg::COL_W] - 1'b1)) begin
						bot_st <= filt_pkg::ST_ZF;
					end else if (row_end) begin
						bot_st <= filt_pkg::ST_C;
					end
				end
				filt_pkg::ST_C: if (row_end) bot_st <= filt_pkg::ST_A;
				filt_pkg::ST_A: begin
					if (data_end) begin
						bot_st <= filt_pkg::ST_IDLE;
					end else if (row_end) begin
						bot_st <= filt_pkg::ST_B;
					end
				end
				filt_pkg::ST_ZF: if (zero_end) bot_st <= filt_pkg::ST_IDLE;
				default: bot_st <= filt_pkg::ST_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			col_cnt <= '0;
			frm_cnt <= '0;
			row_end <= 1'b0;
			data_end <= 1'b0;
		end else begin
			row_end <= 1'b0;
			data_end <= 1'b0;
			if (count_row) begin
				col_cnt <= col_cnt + 1'b1;
				frm_cnt <= frm_cnt + 1'b1;
				row_end <= (col_cnt == filt_pkg::COL_LAST - 1'b1);
				data_end <= (frm_cnt == filt_pkg::FRM_LAST - 1'b1);
			end
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			zf_cnt <= '0;
			zero_end <= 1'b0;
		end else if (count_zero) begin
			zf_cnt <= zf_cnt + 1'b1;
			zero_end <= (zf_cnt == filt_pkg::COL_LAST - 1'b1);
		end else begin
			zf_cnt <= '0;
			zero_end <= 1'b0;
		end
	end

	// Selects follow the read enables by one cycle, in step with RAM data
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			sels <= '0;
		end else begin
			sels <= sel_c;
		end
	end

	a_sel_distinct: assert property (
		@(posedge clk) disable iff (aclr)
		sel_pair_ok(sels.top, sels.mid) && sel_pair_ok(sels.top, sels.bot) &&
		sel_pair_ok(sels.mid, sels.bot)
	);

	a_end_idle: assert property (
		@(posedge clk) disable iff (aclr)
		data_end |=> (top_st == filt_pkg::ST_IDLE) && (mid_st == filt_pkg::ST_IDLE) &&
			(bot_st == filt_pkg::ST_IDLE)
	);

endmodule

// File: design/line_wr_ctrl.sv
`timescale 1ns/1ps

module line_wr_ctrl (
	input  logic                       clk,
	input  logic                       aclr,
	input  logic                       pix_valid,
	output filt_pkg::ram_ctl_t         wren,
	output logic [filt_pkg::COL_W-1:0] wr_addr
);

	logic [filt_pkg::FRM_W-1:0] pix_cnt;
	filt_pkg::ram_ctl_t wr_ptr;

	// The row pointer steps a to b to c after every full row
	// Every frame starts again in RAM a, which is where the row machines expect row 0
	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			pix_cnt <= '0;
			wr_ptr <= '{a: 1'b1, b: 1'b0, c: 1'b0};
		end else if (pix_valid) begin
			pix_cnt <= pix_cnt + 1'b1;
			if (pix_cnt == filt_pkg::FRM_LAST) begin
				wr_ptr <= '{a: 1'b1, b: 1'b0, c: 1'b0};
			end else if (pix_cnt[filt_pkg::COL_W-1:0] == filt_pkg::COL_LAST) begin
				wr_ptr.a <= wr_ptr.c;
				wr_ptr.b <= wr_ptr.a;
				wr_ptr.c <= wr_ptr.b;
			end
		end
	end

	// Pixels are written on the cycle they arrive
	assign wren = pix_valid ? wr_ptr : '0;
	assign wr_addr = pix_cnt[filt_pkg::COL_W-1:0];

	a_wren_onehot: assert property (
		@(posedge clk) disable iff (aclr)
		$onehot0(wren)
	);

endmodule

// File: design/row_ram.sv
`timescale 1ns/1ps

module row_ram (
	input  logic                       clk,
	input  logic                       wren,
	input  logic [filt_pkg::COL_W-1:0] wr_addr,
	input  logic [filt_pkg::PIX_W-1:0] wr_data,
	input  logic                       rden,
	input  logic [filt_pkg::COL_W-1:0] rd_addr,
	output logic [filt_pkg::PIX_W-1:0] rd_data
);

	logic [filt_pkg::PIX_W-1:0] mem [filt_pkg::IMG_W];

	always_ff @(posedge clk) begin
		if (wren) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Same address on both ports returns the old word
	always_ff @(posedge clk) begin
		if (rden) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: design/window_former.sv
`timescale 1ns/1ps

module window_former (
	input  logic                       clk,
	input  logic                       aclr,
	input  filt_pkg::row_sels_t        sels,
	input  logic [filt_pkg::PIX_W-1:0] ram_a,
	input  logic [filt_pkg::PIX_W-1:0] ram_b,
	input  logic [filt_pkg::PIX_W-1:0] ram_c,
	output filt_pkg::window_t          win,
	output logic                       win_valid
);

	typedef struct packed {
		logic [filt_pkg::PIX_W-1:0] top;
		logic [filt_pkg::PIX_W-1:0] mid;
		logic [filt_pkg::PIX_W-1:0] bot;
	} column_t;

	column_t col_in;
	column_t col_a;
	column_t col_b;
	column_t pad_l;
	column_t pad_r;
	logic in_valid;
	logic valid_a;
	logic [filt_pkg::COL_W-1:0] col_cnt;
	logic [filt_pkg::COL_W-1:0] idx_a;

	function automatic logic [filt_pkg::PIX_W-1:0] pick(
		input filt_pkg::row_sel_t s,
		input logic [filt_pkg::PIX_W-1:0] a,
		input logic [filt_pkg::PIX_W-1:0] b,
		input logic [filt_pkg::PIX_W-1:0] c
	);
		case (s)
			filt_pkg::SEL_A: return a;
			filt_pkg::SEL_B: return b;
			filt_pkg::SEL_C: return c;
			default: return '0;
		endcase
	endfunction

	always_comb begin
		col_in.top = pick(sels.top, ram_a, ram_b, ram_c);
		col_in.mid = pick(sels.mid, ram_a, ram_b, ram_c);
		col_in.bot = pick(sels.bot, ram_a, ram_b, ram_c);
	end

	assign in_valid = (sels.mid != filt_pkg::SEL_NONE);

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			col_cnt <= '0;
			idx_a <= '0;
			valid_a <= 1'b0;
		end else begin
			valid_a <= in_valid;
			idx_a <= col_cnt;
			if (in_valid) begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		col_a <= col_in;
		col_b <= col_a;
	end

	// The window is centred on col_a, so the incoming column is its right neighbour
	assign pad_l = (idx_a == '0) ? '0 : col_b;
	assign pad_r = (idx_a == filt_pkg::COL_LAST) ? '0 : col_in;

	always_ff @(posedge clk) begin
		win.p0 <= pad_l.top;
		win.p1 <= col_a.top;
		win.p2 <= pad_r.top;
		win.p3 <= pad_l.mid;
		win.p4 <= col_a.mid;
		win.p5 <= pad_r.mid;
		win.p6 <= pad_l.bot;
		win.p7 <= col_a.bot;
		win.p8 <= pad_r.bot;
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= valid_a;
		end
	end

endmodule

// File: files.f
design/filt_pkg.sv
design/line_wr_ctrl.sv
design/row_ram.sv
design/gen_ram_rden.sv
design/window_former.sv
design/coef_regs.sv
design/conv_mac.sv
design/filter_top.sv
tb/tb_clkgen.sv
tb/tb_filter.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_filter \
	-f files.f -o sim_filter
./obj_dir/sim_filter | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic aclr
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		aclr = 1'b1;
		repeat (5) @(posedge clk);
		aclr <= 1'b0;
	end

endmodule

// File: tb/tb_filter.sv
`timescale 1ns/1ps

module tb_filter;

	// Six tests of at most two frames each, about 90 cycles a frame, with margin
	localparam int timeout_cyc = 2000;

	logic clk;
	logic por_aclr;
	logic rst_req;
	logic aclr;
	logic [7:0] pix_in;
	logic pix_valid;
	logic cfg_wr;
	filt_pkg::coef_cfg_t cfg_in;
	logic [7:0] pix_out;
	logic out_valid;

	filt_pkg::coef_cfg_t cur_cfg;
	filt_pkg::coef_cfg_t ident_cfg;
	logic [7:0] img [64];
	logic [7:0] got_q [$];
	logic [31:0] lfsr_q = 32'h9604_ece5;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;

	assign aclr = por_aclr | rst_req;

	tb_clkgen i_tb_clkgen (
		.clk  (clk),
		.aclr (por_aclr)
	);

	filter_top i_filter_top (
		.clk       (clk),
		.aclr      (aclr),
		.pix_in    (pix_in),
		.pix_valid (pix_valid),
		.cfg_wr    (cfg_wr),
		.cfg_in    (cfg_in),
		.pix_out   (pix_out),
		.out_valid (out_valid)
	);

	always @(posedge clk) begin
		if (out_valid) begin
			got_q.push_back(pix_out);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cyc) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cyc);
			$display("sim failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_bit()};
		end
		return b;
	endfunction

	task automatic fill_random();
		for (int i = 0; i < 64; i++) begin
			img[i] = rand_byte();
		end
	endtask

	task automatic fill_const(input logic [7:0] v);
		for (int i = 0; i < 64; i++) begin
			img[i] = v;
		end
	endtask

	task automatic write_cfg(input filt_pkg::coef_cfg_t c);
		@(posedge clk);
		cfg_in <= c;
		cfg_wr <= 1'b1;
		@(posedge clk);
		cfg_wr <= 1'b0;
		cur_cfg = c;
	endtask

	task automatic send_pixels(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			pix_in <= img[i];
			pix_valid <= 1'b1;
		end
		@(posedge clk);
		pix_valid <= 1'b0;
		pix_in <= '0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int coef_at(input int i);
		case (i)
			0: return int'(cur_cfg.k0);
			1: return int'(cur_cfg.k1);
			2: return int'(cur_cfg.k2);
			3: return int'(cur_cfg.k3);
			4: return int'(cur_cfg.k4);
			5: return int'(cur_cfg.k5);
			6: return int'(cur_cfg.k6);
			7: return int'(cur_cfg.k7);
			default: return int'(cur_cfg.k8);
		endcase
	endfunction

	// Pixels outside the frame count as zero
	function automatic int expected_pix(input int r, input int c);
		int acc;
		int rr;
		int cc;
		int p;
		acc = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				rr = r + dr;
				cc = c + dc;
				p = 0;
				if (rr >= 0 && rr < 8 && cc >= 0 && cc < 8) begin
					p = img[rr * 8 + cc];
				end
				acc += coef_at((dr + 1) * 3 + dc + 1) * p;
			end
		end
		acc = acc >>> cur_cfg.shift;
		if (acc < 0) begin
			return 0;
		end
		if (acc > 255) begin
			return 255;
		end
		return acc;
	endfunction

	task automatic check_frame();
		int e;
		assert (got_q.size() == 64) else begin
			$display("Wrong output count: expected 64 pixels, received %0d", got_q.size());
			err_cnt++;
		end
		for (int i = 0; i < 64 && i < got_q.size(); i++) begin
			e = expected_pix(i / 8, i % 8);
			assert (got_q[i] == e[7:0]) else begin
				$display("MISMATCH pix_out index %0d expected %02h got %02h",
					i, e[7:0], got_q[i]);
				err_cnt++;
			end
		end
	endtask

	task automatic check_row_zero(input int row);
		for (int c = 0; c < 8 && row * 8 + c < got_q.size(); c++) begin
			assert (got_q[row * 8 + c] == 8'h00) else begin
				$display("MISMATCH pix_out index %0d expected 00 got %02h",
					row * 8 + c, got_q[row * 8 + c]);
				err_cnt++;
			end
		end
	endtask

	task automatic run_frame();
		@(negedge clk);
		got_q.delete();
		send_pixels(64);
		while (got_q.size() < 64) @(negedge clk);
		// Extra cycles expose any output beyond the 64th
		repeat (12) @(negedge clk);
		check_frame();
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (err_cnt == err_start) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - err_start);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_identity();
		int err_start;
		err_start = err_cnt;
		repeat (20) begin
			@(negedge clk);
			assert (!out_valid) else begin
				$display("out_valid went high with no frame sent");
				err_cnt++;
			end
		end
		fill_random();
		run_frame();
		finish_test("identity", err_start);
	endtask

	task automatic test_box_blur();
		int err_start;
		filt_pkg::coef_cfg_t c;
		err_start = err_cnt;
		c = '{shift: 3'd3, default: 4'sd1};
		write_cfg(c);
		fill_random();
		run_frame();
		finish_test("box_blur", err_start);
	endtask

	// Centre tap is 7, the largest a 4-bit signed coefficient holds
	task automatic test_laplacian();
		int err_start;
		filt_pkg::coef_cfg_t c;
		err_start = err_cnt;
		c = '{k4: 4'sd7, shift: 3'd0, default: -4'sd1};
		write_cfg(c);
		fill_const(8'hff);
		run_frame();
		fill_const(8'h00);
		img[3 * 8 + 4] = 8'hff;
		run_frame();
		finish_test("laplacian", err_start);
	endtask

	task automatic test_edge_rows();
		int err_start;
		filt_pkg::coef_cfg_t c;
		err_start = err_cnt;
		c = '{k1: 4'sd1, default: '0};
		write_cfg(c);
		fill_random();
		run_frame();
		check_row_zero(0);
		c = '{k7: 4'sd1, default: '0};
		write_cfg(c);
		fill_random();
		run_frame();
		check_row_zero(7);
		finish_test("edge_rows", err_start);
	endtask

	task automatic test_two_frames();
		int err_start;
		filt_pkg::coef_cfg_t c;
		err_start = err_cnt;
		c = '{shift: 3'd3, default: 4'sd1};
		write_cfg(c);
		fill_random();
		run_frame();
		// Sharpen kernel for the second frame
		c = '{k1: -4'sd1, k3: -4'sd1, k4: 4'sd5, k5: -4'sd1, k7: -4'sd1, default: '0};
		write_cfg(c);
		fill_random();
		run_frame();
		finish_test("two_frames", err_start);
	endtask

	task automatic test_mid_reset();
		int err_start;
		err_start = err_cnt;
		fill_random();
		@(negedge clk);
		got_q.delete();
		send_pixels(40);
		@(posedge clk);
		rst_req <= 1'b1;
		repeat (5) begin
			@(negedge clk);
			assert (!out_valid) else begin
				$display("out_valid stayed high while reset was asserted");
				err_cnt++;
			end
		end
		@(posedge clk);
		rst_req <= 1'b0;
		// Reset also restores the identity kernel
		cur_cfg = ident_cfg;
		@(negedge clk);
		got_q.delete();
		repeat (20) @(negedge clk);
		assert (got_q.size() == 0) else begin
			$display("%0d pixels came out after reset with no frame sent", got_q.size());
			err_cnt++;
		end
		fill_random();
		run_frame();
		finish_test("mid_reset", err_start);
	endtask

	initial begin
		pix_in = '0;
		pix_valid = 1'b0;
		cfg_wr = 1'b0;
		cfg_in = '0;
		rst_req = 1'b0;
		ident_cfg = '{k4: 4'sd1, default: '0};
		cur_cfg = ident_cfg;
		@(negedge clk);
		while (aclr) @(negedge clk);
		test_identity();
		test_box_blur();
		test_laplacian();
		test_edge_rows();
		test_two_frames();
		test_mid_reset();
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
